// File: hdl/axi_mem_defines.svh
`ifndef AXI_MEM_DEFINES_SVH
`define AXI_MEM_DEFINES_SVH

// sram region of 64-bit words
`define AXI_MEM_SRAM_BASE 32'h8000_0000
`define AXI_MEM_SRAM_WORDS 256

// uart transmit register window
`define AXI_MEM_UART_BASE 32'h1000_0000
`define AXI_MEM_UART_BYTES 8

// 1 lets the lfsr stall the access stage
`define AXI_MEM_STALL_EN 1

// must be nonzero or the lfsr locks up
`define AXI_MEM_LFSR_SEED 20'd101

`endif

// File: hdl/axi_mem_pkg.sv
package axi_mem_pkg;

  typedef enum logic [0:0] {
    op_read  = 1'b0,
    op_write = 1'b1
  } access_op_e;

  typedef enum logic [1:0] {
    tgt_sram = 2'd0,
    tgt_uart = 2'd1,
    tgt_none = 2'd2
  } target_e;

  // axi xresp encodings used by this slave
  typedef enum logic [1:0] {
    resp_okay   = 2'd0,
    resp_decerr = 2'd3
  } axi_resp_e;

  typedef enum logic [1:0] {
    dec_idle  = 2'd0,
    dec_issue = 2'd1,
    dec_wait  = 2'd2
  } dec_state_e;

  typedef enum logic [0:0] {
    res_idle = 1'b0,
    res_hold = 1'b1
  } res_state_e;

endpackage

// File: hdl/axi_req_decode.sv
`timescale 1ns/1ps
`include "axi_mem_defines.svh"

module axi_req_decode
  import axi_mem_pkg::*;
(
  input  logic             clk,
  input  logic             arst_n_i,
  input  logic             arvalid_i,
  input  logic [31:0]      araddr_i,
  input  logic [3:0]       arid_i,
  output logic             arready_o,
  input  logic             awvalid_i,
  input  logic [31:0]      awaddr_i,
  input  logic [3:0]       awid_i,
  output logic             awready_o,
  input  logic             wvalid_i,
  input  logic [63:0]      wdata_i,
  input  logic [7:0]       wstrb_i,
  output logic             wready_o,
  input  logic             req_ready_i,
  input  logic             resp_taken_i,
  output logic             req_valid_o,
  output access_op_e       req_op_o,
  output target_e          req_target_o,
  output logic [3:0]       req_id_o,
  output logic [7:0]       req_word_o,
  output logic [63:0]      req_wdata_o,
  output logic [7:0]       req_wstrb_o
);

  dec_state_e  state_q;
  logic        accept_rd;
  logic        accept_wr;
  logic [31:0] sel_addr;
  logic [31:0] sram_offset;

  // address map lookup ignoring bits [2:0]
  function automatic target_e map_target(input logic [31:0] addr);
    logic [31:0] sram_off;
    logic [31:0] uart_off;
    sram_off = addr - `AXI_MEM_SRAM_BASE;
    uart_off = addr - `AXI_MEM_UART_BASE;
    if (sram_off < `AXI_MEM_SRAM_WORDS * 8) begin
      return tgt_sram;
    end else if (uart_off < `AXI_MEM_UART_BYTES) begin
      return tgt_uart;
    end
    return tgt_none;
  endfunction

  // read wins over write when both are pending
  assign accept_rd = (state_q == dec_idle) && arvalid_i;
  assign accept_wr = (state_q == dec_idle) && !arvalid_i && awvalid_i && wvalid_i;

  assign arready_o = accept_rd;
  assign awready_o = accept_wr;
  assign wready_o  = accept_wr;

  assign sel_addr    = accept_rd ? araddr_i : awaddr_i;
  assign sram_offset = sel_addr - `AXI_MEM_SRAM_BASE;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= dec_idle;
    end else begin
      case (state_q)
        dec_idle: begin
          if (accept_rd || accept_wr) begin
            state_q <= dec_issue;
          end
        end
        dec_issue: begin
          if (req_ready_i) begin
            state_q <= dec_wait;
          end
        end
        dec_wait: begin
          // hold off new requests until the response is gone
          if (resp_taken_i) begin
            state_q <= dec_idle;
          end
        end
        default: state_q <= dec_idle;
      endcase
    end
  end

  // captured request
  always_ff @(posedge clk) begin
    if (accept_rd || accept_wr) begin
      req_op_o     <= accept_rd ? op_read : op_write;
      req_target_o <= map_target(sel_addr);
      req_id_o     <= accept_rd ? arid_i : awid_i;
      req_word_o   <= sram_offset[10:3];
      req_wdata_o  <= wdata_i;
      req_wstrb_o  <= accept_rd ? 8'h00 : wstrb_i;
    end
  end

  assign req_valid_o = (state_q == dec_issue);

endmodule

// File: hdl/axi_mem_execute.sv
`timescale 1ns/1ps
`include "axi_mem_defines.svh"

module axi_mem_execute
  import axi_mem_pkg::*;
(
  input  logic        clk,
  input  logic        arst_n_i,
  input  logic        req_valid_i,
  input  access_op_e  req_op_i,
  input  target_e     req_target_i,
  input  logic [3:0]  req_id_i,
  input  logic [7:0]  req_word_i,
  input  logic [63:0] req_wdata_i,
  input  logic [7:0]  req_wstrb_i,
  output logic        req_ready_o,
  output logic        done_valid_o,
  output access_op_e  done_op_o,
  output logic [3:0]  done_id_o,
  output logic [63:0] done_rdata_o,
  output axi_resp_e   done_resp_o,
  output logic        uart_tx_valid_o,
  output logic [7:0]  uart_tx_data_o
);

  logic [63:0] mem_q [0:`AXI_MEM_SRAM_WORDS-1];
  logic [19:0] lfsr_q;
  logic        take;
  logic        sram_wr;
  logic        uart_wr;

  // top lfsr bit low means the memory is busy this cycle
  assign req_ready_o = (`AXI_MEM_STALL_EN != 0) ? lfsr_q[19] : 1'b1;
  assign take        = req_valid_i && req_ready_o;

  assign sram_wr = take && (req_op_i == op_write) && (req_target_i == tgt_sram);
  assign uart_wr = take && (req_op_i == op_write) && (req_target_i == tgt_uart)
                   && req_wstrb_i[0];

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      lfsr_q          <= `AXI_MEM_LFSR_SEED;
      done_valid_o    <= 1'b0;
      uart_tx_valid_o <= 1'b0;
    end else begin
      lfsr_q          <= {lfsr_q[18:0], lfsr_q[19] ^ lfsr_q[18]};
      done_valid_o    <= take;
      uart_tx_valid_o <= uart_wr;
    end
  end

  // byte lanes under the strobe
  always_ff @(posedge clk) begin
    if (sram_wr) begin
      for (int b = 0; b < 8; b++) begin
        if (req_wstrb_i[b]) begin
          mem_q[req_word_i][b*8 +: 8] <= req_wdata_i[b*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      done_op_o <= req_op_i;
      done_id_o <= req_id_i;
      case (req_target_i)
        tgt_sram: begin
          done_rdata_o <= (req_op_i == op_read) ? mem_q[req_word_i] : 64'h0;
          done_resp_o  <= resp_okay;
        end
        tgt_uart: begin
          // transmit register reads back as zero
          done_rdata_o <= 64'h0;
          done_resp_o  <= resp_okay;
        end
        default: begin
          done_rdata_o <= 64'h0;
          done_resp_o  <= resp_decerr;
        end
      endcase
    end
    if (uart_wr) begin
      uart_tx_data_o <= req_wdata_i[7:0];
    end
  end

endmodule

// File: hdl/axi_resp_result.sv
`timescale 1ns/1ps

module axi_resp_result
  import axi_mem_pkg::*;
(
  input  logic        clk,
  input  logic        arst_n_i,
  input  logic        done_valid_i,
  input  access_op_e  done_op_i,
  input  logic [3:0]  done_id_i,
  input  logic [63:0] done_rdata_i,
  input  axi_resp_e   done_resp_i,
  input  logic        rready_i,
  input  logic        bready_i,
  output logic        rvalid_o,
  output logic [3:0]  rid_o,
  output logic [63:0] rdata_o,
  output logic [1:0]  rresp_o,
  output logic        bvalid_o,
  output logic [3:0]  bid_o,
  output logic [1:0]  bresp_o,
  output logic        resp_taken_o
);

  res_state_e state_q;
  logic       load;
  logic       handshake;

  assign load      = (state_q == res_idle) && done_valid_i;
  assign handshake = (rvalid_o && rready_i) || (bvalid_o && bready_i);

  // one pulse per completed r or b beat
  assign resp_taken_o = (state_q == res_hold) && handshake;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q  <= res_idle;
      rvalid_o <= 1'b0;
      bvalid_o <= 1'b0;
    end else begin
      case (state_q)
        res_idle: begin
          if (load) begin
            state_q  <= res_hold;
            rvalid_o <= (done_op_i == op_read);
            bvalid_o <= (done_op_i == op_write);
          end
        end
        res_hold: begin
          if (handshake) begin
            state_q  <= res_idle;
            rvalid_o <= 1'b0;
            bvalid_o <= 1'b0;
          end
        end
        default: state_q <= res_idle;
      endcase
    end
  end

  // payload only loads in res_idle, so it is stable while valid is up
  always_ff @(posedge clk) begin
    if (load && (done_op_i == op_read)) begin
      rid_o   <= done_id_i;
      rdata_o <= done_rdata_i;
      rresp_o <= done_resp_i;
    end
    if (load && (done_op_i == op_write)) begin
      bid_o   <= done_id_i;
      bresp_o <= done_resp_i;
    end
  end

endmodule

// File: hdl/axi_mem_top.sv
`timescale 1ns/1ps
`include "axi_mem_defines.svh"

module axi_mem_top
  import axi_mem_pkg::*;
(
  input  logic        clk,
  input  logic        arst_n_i,
  input  logic        arvalid_i,
  input  logic [31:0] araddr_i,
  input  logic [3:0]  arid_i,
  output logic        arready_o,
  input  logic        awvalid_i,
  input  logic [31:0] awaddr_i,
  input  logic [3:0]  awid_i,
  output logic        awready_o,
  input  logic        wvalid_i,
  input  logic [63:0] wdata_i,
  input  logic [7:0]  wstrb_i,
  output logic        wready_o,
  input  logic        rready_i,
  output logic        rvalid_o,
  output logic [3:0]  rid_o,
  output logic [63:0] rdata_o,
  output logic [1:0]  rresp_o,
  input  logic        bready_i,
  output logic        bvalid_o,
  output logic [3:0]  bid_o,
  output logic [1:0]  bresp_o,
  output logic        uart_tx_valid_o,
  output logic [7:0]  uart_tx_data_o
);

  localparam int WordW = $clog2(`AXI_MEM_SRAM_WORDS);

  // decode to execute
  logic             req_valid;
  logic             req_ready;
  access_op_e       req_op;
  target_e          req_target;
  logic [3:0]       req_id;
  logic [WordW-1:0] req_word;
  logic [63:0]      req_wdata;
  logic [7:0]       req_wstrb;

  // execute to result
  logic             done_valid;
  access_op_e       done_op;
  logic [3:0]       done_id;
  logic [63:0]      done_rdata;
  axi_resp_e        done_resp;

  logic             resp_taken;

  axi_req_decode u_decode (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .arvalid_i    (arvalid_i),
    .araddr_i     (araddr_i),
    .arid_i       (arid_i),
    .arready_o    (arready_o),
    .awvalid_i    (awvalid_i),
    .awaddr_i     (awaddr_i),
    .awid_i       (awid_i),
    .awready_o    (awready_o),
    .wvalid_i     (wvalid_i),
    .wdata_i      (wdata_i),
    .wstrb_i      (wstrb_i),
    .wready_o     (wready_o),
    .req_ready_i  (req_ready),
    .resp_taken_i (resp_taken),
    .req_valid_o  (req_valid),
    .req_op_o     (req_op),
    .req_target_o (req_target),
    .req_id_o     (req_id),
    .req_word_o   (req_word),
    .req_wdata_o  (req_wdata),
    .req_wstrb_o  (req_wstrb)
  );

  axi_mem_execute u_execute (
    .clk             (clk),
    .arst_n_i        (arst_n_i),
    .req_valid_i     (req_valid),
    .req_op_i        (req_op),
    .req_target_i    (req_target),
    .req_id_i        (req_id),
    .req_word_i      (req_word),
    .req_wdata_i     (req_wdata),
    .req_wstrb_i     (req_wstrb),
    .req_ready_o     (req_ready),
    .done_valid_o    (done_valid),
    .done_op_o       (done_op),
    .done_id_o       (done_id),
    .done_rdata_o    (done_rdata),
    .done_resp_o     (done_resp),
    .uart_tx_valid_o (uart_tx_valid_o),
    .uart_tx_data_o  (uart_tx_data_o)
  );

  axi_resp_result u_result (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .done_valid_i (done_valid),
    .done_op_i    (done_op),
    .done_id_i    (done_id),
    .done_rdata_i (done_rdata),
    .done_resp_i  (done_resp),
    .rready_i     (rready_i),
    .bready_i     (bready_i),
    .rvalid_o     (rvalid_o),
    .rid_o        (rid_o),
    .rdata_o      (rdata_o),
    .rresp_o      (rresp_o),
    .bvalid_o     (bvalid_o),
    .bid_o        (bid_o),
    .bresp_o      (bresp_o),
    .resp_taken_o (resp_taken)
  );

endmodule

// File: verif/axi_mem_checker.sv
`timescale 1ns/1ps

module axi_mem_checker (
  input logic        clk,
  input logic        arst_n_i,
  input logic        arready_o,
  input logic        awready_o,
  input logic        wready_o,
  input logic        rready_i,
  input logic        rvalid_o,
  input logic [3:0]  rid_o,
  input logic [63:0] rdata_o,
  input logic [1:0]  rresp_o,
  input logic        bready_i,
  input logic        bvalid_o,
  input logic [3:0]  bid_o,
  input logic [1:0]  bresp_o,
  input logic        uart_tx_valid_o
);

  int unsigned fail_count = 0;

  // all valids and readys quiet while reset is held
  reset_quiet: assert property (@(posedge clk)
    !arst_n_i |-> !rvalid_o && !bvalid_o && !uart_tx_valid_o && !arready_o && !awready_o)
    else begin
      $error("valid or ready high during reset");
      fail_count++;
    end

  r_held: assert property (@(posedge clk) disable iff (!arst_n_i)
    rvalid_o && !rready_i |=> rvalid_o && $stable(rdata_o) && $stable(rid_o) && $stable(rresp_o))
    else begin
      $error("r channel changed before rready");
      fail_count++;
    end

  b_held: assert property (@(posedge clk) disable iff (!arst_n_i)
    bvalid_o && !bready_i |=> bvalid_o && $stable(bid_o) && $stable(bresp_o))
    else begin
      $error("b channel changed before bready");
      fail_count++;
    end

  aw_w_paired: assert property (@(posedge clk) disable iff (!arst_n_i)
    awready_o == wready_o)
    else begin
      $error("awready and wready differ");
      fail_count++;
    end

  // single transaction in flight
  no_accept_busy: assert property (@(posedge clk) disable iff (!arst_n_i)
    (rvalid_o || bvalid_o) |-> !arready_o && !awready_o)
    else begin
      $error("request accepted while a response is pending");
      fail_count++;
    end

endmodule

bind axi_mem_top axi_mem_checker chk0 (
  .clk             (clk),
  .arst_n_i        (arst_n_i),
  .arready_o       (arready_o),
  .awready_o       (awready_o),
  .wready_o        (wready_o),
  .rready_i        (rready_i),
  .rvalid_o        (rvalid_o),
  .rid_o           (rid_o),
  .rdata_o         (rdata_o),
  .rresp_o         (rresp_o),
  .bready_i        (bready_i),
  .bvalid_o        (bvalid_o),
  .bid_o           (bid_o),
  .bresp_o         (bresp_o),
  .uart_tx_valid_o (uart_tx_valid_o)
);

// File: verif/axi_mem_tb.sv
`timescale 1ns/1ps
`include "axi_mem_defines.svh"

module axi_mem_tb
  import axi_mem_pkg::*;
();

  localparam int Words = `AXI_MEM_SRAM_WORDS;
  // 200 transactions at up to 64 cycles each
  localparam int MaxCycles = 200 * 64;

  logic        clk;
  logic        arst_n_i;
  logic        arvalid_i;
  logic [31:0] araddr_i;
  logic [3:0]  arid_i;
  logic        arready_o;
  logic        awvalid_i;
  logic [31:0] awaddr_i;
  logic [3:0]  awid_i;
  logic        awready_o;
  logic        wvalid_i;
  logic [63:0] wdata_i;
  logic [7:0]  wstrb_i;
  logic        wready_o;
  logic        rready_i;
  logic        rvalid_o;
  logic [3:0]  rid_o;
  logic [63:0] rdata_o;
  logic [1:0]  rresp_o;
  logic        bready_i;
  logic        bvalid_o;
  logic [3:0]  bid_o;
  logic [1:0]  bresp_o;
  logic        uart_tx_valid_o;
  logic [7:0]  uart_tx_data_o;

  logic [7:0] ref_mem [Words*8];
  int         written_q[$];
  int         cycle_count = 0;
  int         uart_count;
  logic [7:0] uart_byte;

  axi_mem_top dut0 (.*);

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= MaxCycles) begin
      $display("Timeout: the run did not finish within %0d cycles", MaxCycles);
      $display("Checks failed");
      $fatal(1, "timeout");
    end
  end

  always @(negedge clk) begin
    if (dut0.chk0.fail_count != 0) begin
      $display("A protocol assertion in the bound checker failed");
      $display("Checks failed");
      $fatal(1, "protocol violation");
    end
  end

  // one-cycle uart pulse is seen on exactly one falling edge
  always @(negedge clk) begin
    if (uart_tx_valid_o) begin
      uart_count++;
      uart_byte = uart_tx_data_o;
    end
  end

  function automatic logic [31:0] sram_addr(input int idx);
    return `AXI_MEM_SRAM_BASE + 32'(idx * 8);
  endfunction

  function automatic logic [63:0] model_word(input int idx);
    logic [63:0] w;
    for (int b = 0; b < 8; b++) begin
      w[b*8 +: 8] = ref_mem[idx*8 + b];
    end
    return w;
  endfunction

  function automatic void model_write(input int idx, input logic [63:0] data,
                                      input logic [7:0] strb);
    for (int b = 0; b < 8; b++) begin
      if (strb[b]) begin
        ref_mem[idx*8 + b] = data[b*8 +: 8];
      end
    end
  endfunction

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (act === exp) else begin
      $display("** Error %s: expected %h actual %h", name, exp, act);
      $display("Checks failed");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  // ready is combinational, so look just after the falling edge
  task automatic accept_read();
    #1;
    while (!arready_o) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    arvalid_i = 1'b0;
  endtask

  task automatic accept_write();
    #1;
    while (!awready_o) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    awvalid_i = 1'b0;
    wvalid_i  = 1'b0;
  endtask

  task automatic take_r(input int max_delay, output logic [63:0] data,
                        output logic [1:0] resp, output logic [3:0] id);
    while (!rvalid_o) begin
      @(negedge clk);
    end
    repeat ($urandom_range(max_delay)) begin
      @(negedge clk);
    end
    rready_i = 1'b1;
    data     = rdata_o;
    resp     = rresp_o;
    id       = rid_o;
    @(negedge clk);
    rready_i = 1'b0;
  endtask

  task automatic take_b(input int max_delay, output logic [1:0] resp, output logic [3:0] id);
    while (!bvalid_o) begin
      @(negedge clk);
    end
    repeat ($urandom_range(max_delay)) begin
      @(negedge clk);
    end
    bready_i = 1'b1;
    resp     = bresp_o;
    id       = bid_o;
    @(negedge clk);
    bready_i = 1'b0;
  endtask

  task automatic read_word(input string name, input logic [31:0] addr,
                           input logic [63:0] exp_data, input logic [1:0] exp_resp);
    logic [3:0]  id;
    logic [3:0]  rid;
    logic [63:0] data;
    logic [1:0]  resp;
    id        = 4'($urandom);
    arvalid_i = 1'b1;
    araddr_i  = addr;
    arid_i    = id;
    accept_read();
    take_r(0, data, resp, rid);
    check_value({name, " rdata"}, exp_data, data);
    check_value({name, " rresp"}, exp_resp, resp);
    check_value({name, " rid"}, id, rid);
  endtask

  task automatic write_word(input string name, input logic [31:0] addr, input logic [63:0] data,
                            input logic [7:0] strb, input logic [1:0] exp_resp);
    logic [3:0] id;
    logic [3:0] bid;
    logic [1:0] resp;
    id        = 4'($urandom);
    awvalid_i = 1'b1;
    awaddr_i  = addr;
    awid_i    = id;
    wvalid_i  = 1'b1;
    wdata_i   = data;
    wstrb_i   = strb;
    accept_write();
    take_b(0, resp, bid);
    check_value({name, " bresp"}, exp_resp, resp);
    check_value({name, " bid"}, id, bid);
  endtask

  // ar and aw/w raised on the same edge with slow rready and bready
  task automatic read_and_write(input int ridx, input int widx, input logic [63:0] data,
                                input logic [7:0] strb);
    logic [3:0]  rid_exp;
    logic [3:0]  bid_exp;
    logic [3:0]  id;
    logic [63:0] exp_rd;
    logic [63:0] rdata;
    logic [1:0]  resp;
    rid_exp   = 4'($urandom);
    bid_exp   = 4'($urandom);
    exp_rd    = model_word(ridx);
    arvalid_i = 1'b1;
    araddr_i  = sram_addr(ridx);
    arid_i    = rid_exp;
    awvalid_i = 1'b1;
    awaddr_i  = sram_addr(widx);
    awid_i    = bid_exp;
    wvalid_i  = 1'b1;
    wdata_i   = data;
    wstrb_i   = strb;
    #1;
    check_value("dual arready first", 1, arready_o);
    check_value("dual awready held", 0, awready_o);
    accept_read();
    take_r(6, rdata, resp, id);
    check_value("dual rdata", exp_rd, rdata);
    check_value("dual rresp", resp_okay, resp);
    check_value("dual rid", rid_exp, id);
    accept_write();
    take_b(6, resp, id);
    check_value("dual bresp", resp_okay, resp);
    check_value("dual bid", bid_exp, id);
    model_write(widx, data, strb);
  endtask

  initial begin
    logic [63:0] data;
    logic [7:0]  strb;
    logic [31:0] holes [4];
    int          idx;
    void'($urandom(83812));
    clk        = 1'b0;
    arst_n_i   = 1'b1;
    arvalid_i  = 1'b0;
    araddr_i   = '0;
    arid_i     = '0;
    awvalid_i  = 1'b0;
    awaddr_i   = '0;
    awid_i     = '0;
    wvalid_i   = 1'b0;
    wdata_i    = '0;
    wstrb_i    = '0;
    rready_i   = 1'b0;
    bready_i   = 1'b0;
    uart_count = 0;
    holes      = '{32'h0000_0000, 32'h8000_0800, 32'h1000_0008, 32'h7fff_fff8};
    @(negedge clk);
    arst_n_i = 1'b0;
    repeat (10) @(negedge clk);
    arst_n_i = 1'b1;

    // full-word writes, each read straight back
    for (int i = 0; i < 20; i++) begin
      idx  = $urandom_range(Words - 1);
      data = {$urandom, $urandom};
      write_word("full write", sram_addr(idx), data, 8'hff, resp_okay);
      model_write(idx, data, 8'hff);
      written_q.push_back(idx);
      read_word("full readback", sram_addr(idx), model_word(idx), resp_okay);
    end

    // partial strobes over words that are already known
    for (int i = 0; i < 10; i++) begin
      idx  = written_q[$urandom_range(written_q.size() - 1)];
      data = {$urandom, $urandom};
      strb = 8'($urandom_range(254, 1));
      write_word("strobed write", sram_addr(idx), data, strb, resp_okay);
      model_write(idx, data, strb);
      read_word("strobed readback", sram_addr(idx), model_word(idx), resp_okay);
    end

    for (int i = 0; i < 3; i++) begin
      uart_count = 0;
      data       = {$urandom, $urandom};
      write_word("uart write", `AXI_MEM_UART_BASE, data, 8'h01, resp_okay);
      check_value("uart pulse count", 1, uart_count);
      check_value("uart byte", data[7:0], uart_byte);
    end
    uart_count = 0;
    write_word("uart no strobe", `AXI_MEM_UART_BASE, data, 8'hfe, resp_okay);
    check_value("uart no strobe pulse count", 0, uart_count);
    read_word("uart read", `AXI_MEM_UART_BASE, 64'h0, resp_okay);

    data = {$urandom, $urandom};
    write_word("sram word 0", sram_addr(0), data, 8'hff, resp_okay);
    model_write(0, data, 8'hff);
    written_q.push_back(0);
    foreach (holes[i]) begin
      write_word("unmapped write", holes[i], ~data, 8'hff, resp_decerr);
      read_word("unmapped read", holes[i], 64'h0, resp_decerr);
    end
    read_word("sram after unmapped", sram_addr(0), model_word(0), resp_okay);

    for (int i = 0; i < 20; i++) begin
      data = {$urandom, $urandom};
      strb = 8'($urandom_range(255, 1));
      read_and_write(written_q[$urandom_range(written_q.size() - 1)],
                     written_q[$urandom_range(written_q.size() - 1)], data, strb);
    end

    @(negedge clk);
    if (dut0.chk0.fail_count == 0) begin
      $display("All checks passed");
      $finish;
    end else begin
      $display("Checks failed");
      $fatal(1, "bound checker reported errors");
    end
  end

endmodule

// File: build.f
+incdir+hdl
hdl/axi_mem_pkg.sv
hdl/axi_req_decode.sv
hdl/axi_mem_execute.sv
hdl/axi_resp_result.sv
hdl/axi_mem_top.sv
verif/axi_mem_checker.sv
verif/axi_mem_tb.sv

// File: Bender.yml
package:
  name: axi_mem

export_include_dirs:
  - hdl

sources:
  - hdl/axi_mem_pkg.sv
  - hdl/axi_req_decode.sv
  - hdl/axi_mem_execute.sv
  - hdl/axi_resp_result.sv
  - hdl/axi_mem_top.sv
  - target: test
    files:
      - verif/axi_mem_checker.sv
      - verif/axi_mem_tb.sv
